// File: rtl/pcie_rx_pkg.sv
package pcie_rx_pkg;

    localparam int FLOW_IDX_WIDTH = 6;
    localparam int APP_IDX_WIDTH = 4;

    typedef logic [FLOW_IDX_WIDTH-1:0] flow_idx_t;
    typedef logic [APP_IDX_WIDTH-1:0] app_idx_t;

    localparam int MAX_NB_FLOWS = 64;

    // Register width in bytes and slot of the head register in a queue block
    localparam int REG_SIZE = 4;
    localparam int HEAD_REG_SLOT = 1;

    // Each queue owns a 4 KiB page of the MMIO window
    localparam int QUEUE_ADDR_LSB = 12;

    typedef struct packed {
        logic [63:0] address;
        logic [63:0] byteenable;
        logic        write;
    } mmio_write_t;

    typedef struct packed {
        app_idx_t    dsc_queue_id;
        flow_idx_t   pkt_queue_id;
        logic [15:0] size;
    } rx_meta_t;

    typedef struct packed {
        app_idx_t    dsc_queue_id;
        flow_idx_t   pkt_queue_id;
        logic [15:0] size;
        logic        descriptor_only;
        logic        needs_dsc;
    } queued_meta_t;

    typedef enum logic [1:0] {
        GRANT_NONE   = 2'd0,
        GRANT_HEAD   = 2'd1,
        GRANT_META   = 2'd2,
        GRANT_MERGED = 2'd3
    } arb_grant_e;

endpackage

// File: rtl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             pcie_clk,
    input  logic             pcie_reset_n,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [31:0]      level
);

localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

logic [WIDTH-1:0] mem [DEPTH];
logic [AW-1:0]    wr_ptr;
logic [AW-1:0]    rd_ptr;
logic [31:0]      count;
logic             push;
logic             pop;

assign in_ready  = count < 32'(DEPTH);
assign out_valid = count != 0;
assign push      = in_valid & in_ready;
assign pop       = out_valid & out_ready;
assign level     = count;

// Show-ahead read, the head entry is visible as soon as it is written
assign out_data = mem[rd_ptr];

always_ff @(posedge pcie_clk) begin
    if (push) begin
        mem[wr_ptr] <= in_data;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
        if (push && !pop) begin
            count <= count + 1;
        end else if (pop && !push) begin
            count <= count - 1;
        end
    end
end

endmodule

// File: rtl/head_upd_monitor.sv
`timescale 1ns/1ps

module head_upd_monitor #(
    parameter int HEAD_QUEUE_DEPTH = 128,
    parameter int MAX_NB_FLOWS = 64
) (
    input  logic                     pcie_clk,
    input  logic                     pcie_reset_n,
    input  pcie_rx_pkg::mmio_write_t mmio_wr,
    input  logic                     sw_reset_req,
    output pcie_rx_pkg::flow_idx_t   head_flow,
    output logic                     head_valid,
    input  logic                     head_ready,
    output logic                     sw_reset,
    output logic [31:0]              rx_ignored_head_cnt
);

localparam int QUEUE_NUM_WIDTH = 16;
localparam int HEAD_LANE = pcie_rx_pkg::HEAD_REG_SLOT * pcie_rx_pkg::REG_SIZE;

logic [QUEUE_NUM_WIDTH-1:0] queue_num;
logic                       head_write;
logic                       push_valid;
pcie_rx_pkg::flow_idx_t     push_flow;
logic                       fifo_in_ready;
logic [31:0]                fifo_level;
logic                       fifo_almost_full;
logic                       sw_reset_r1;

assign queue_num = mmio_wr.address[pcie_rx_pkg::QUEUE_ADDR_LSB +: QUEUE_NUM_WIDTH];

// A head update needs the whole head register written in one beat
assign head_write = mmio_wr.write && (queue_num < QUEUE_NUM_WIDTH'(MAX_NB_FLOWS)) &&
    (mmio_wr.byteenable[HEAD_LANE +: pcie_rx_pkg::REG_SIZE] ==
     {pcie_rx_pkg::REG_SIZE{1'b1}});

// Leave room for writes still in flight towards the FIFO
assign fifo_almost_full = fifo_level > 32'(HEAD_QUEUE_DEPTH - 4);

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        push_valid          <= 1'b0;
        rx_ignored_head_cnt <= '0;
    end else begin
        push_valid <= 1'b0;
        if (head_write) begin
            if (!fifo_almost_full && fifo_in_ready) begin
                push_valid <= 1'b1;
            end else begin
                rx_ignored_head_cnt <= rx_ignored_head_cnt + 1;
            end
        end
    end
end

always_ff @(posedge pcie_clk) begin
    push_flow <= pcie_rx_pkg::flow_idx_t'(queue_num);
end

sync_fifo #(
    .WIDTH ($bits(pcie_rx_pkg::flow_idx_t)),
    .DEPTH (HEAD_QUEUE_DEPTH)
) head_upd_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (push_flow),
    .in_valid     (push_valid),
    .in_ready     (fifo_in_ready),
    .out_data     (head_flow),
    .out_valid    (head_valid),
    .out_ready    (head_ready),
    .level        (fifo_level)
);

// Two flops between the software request and the stats clear
always_ff @(posedge pcie_clk) begin
    sw_reset_r1 <= sw_reset_req;
    sw_reset    <= sw_reset_r1;
end

endmodule

// File: rtl/meta_merge_arbiter.sv
`timescale 1ns/1ps

module meta_merge_arbiter #(
    parameter int IN_QUEUE_DEPTH = 8
) (
    input  logic                      pcie_clk,
    input  logic                      pcie_reset_n,
    input  logic                      sw_reset,
    input  pcie_rx_pkg::flow_idx_t    head_flow,
    input  logic                      head_valid,
    output logic                      head_ready,
    input  pcie_rx_pkg::rx_meta_t     rx_meta,
    input  logic                      rx_meta_valid,
    output logic                      rx_meta_ready,
    input  logic [31:0]               in_queue_level,
    output pcie_rx_pkg::queued_meta_t rec,
    output logic                      rec_valid,
    output logic [31:0]               rx_pkt_head_upd_cnt
);

pcie_rx_pkg::arb_grant_e   grant;
pcie_rx_pkg::queued_meta_t next_rec;
logic                      running;
logic                      room;
logic                      same_queue;

// Starts one cycle after reset is released
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        running <= 1'b0;
    end else begin
        running <= 1'b1;
    end
end

// The record already on its way counts against the in-queue threshold
assign room = running &&
    ((in_queue_level + {31'b0, rec_valid}) <= 32'(IN_QUEUE_DEPTH - 4));

assign same_queue = rx_meta.pkt_queue_id == head_flow;

// Head updates win; a packet for the same queue rides along with one
always_comb begin
    grant = pcie_rx_pkg::GRANT_NONE;
    if (room) begin
        if (head_valid) begin
            if (rx_meta_valid && same_queue) begin
                grant = pcie_rx_pkg::GRANT_MERGED;
            end else begin
                grant = pcie_rx_pkg::GRANT_HEAD;
            end
        end else if (rx_meta_valid) begin
            grant = pcie_rx_pkg::GRANT_META;
        end
    end
end

assign head_ready    = room;
assign rx_meta_ready = room && (!head_valid || same_queue);

always_comb begin
    next_rec.dsc_queue_id    = rx_meta.dsc_queue_id;
    next_rec.pkt_queue_id    = rx_meta.pkt_queue_id;
    next_rec.size            = rx_meta.size;
    next_rec.descriptor_only = 1'b0;
    next_rec.needs_dsc       = grant == pcie_rx_pkg::GRANT_MERGED;
    if (grant == pcie_rx_pkg::GRANT_HEAD) begin
        // Descriptor-only record, the descriptor queue is resolved downstream
        next_rec.dsc_queue_id    = '0;
        next_rec.pkt_queue_id    = head_flow;
        next_rec.size            = '0;
        next_rec.descriptor_only = 1'b1;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        rec_valid <= 1'b0;
    end else begin
        rec_valid <= grant != pcie_rx_pkg::GRANT_NONE;
    end
end

always_ff @(posedge pcie_clk) begin
    rec <= next_rec;
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n || sw_reset) begin
        rx_pkt_head_upd_cnt <= '0;
    end else if (head_valid && head_ready) begin
        rx_pkt_head_upd_cnt <= rx_pkt_head_upd_cnt + 1;
    end
end

endmodule

// File: rtl/pqm_dispatch.sv
`timescale 1ns/1ps

module pqm_dispatch #(
    parameter int IN_QUEUE_DEPTH = 8,
    parameter int NB_PKT_QUEUE_MANAGERS = 2
) (
    input  logic                             pcie_clk,
    input  logic                             pcie_reset_n,
    input  pcie_rx_pkg::queued_meta_t        rec,
    input  logic                             rec_valid,
    output logic [31:0]                      in_queue_level,
    output pcie_rx_pkg::queued_meta_t        pqm_meta,
    output logic [NB_PKT_QUEUE_MANAGERS-1:0] pqm_valid,
    input  logic [NB_PKT_QUEUE_MANAGERS-1:0] pqm_ready
);

localparam int QM_ID_WIDTH = $clog2(NB_PKT_QUEUE_MANAGERS);
// Keeps the id one bit wide when there is a single manager
localparam int QM_ID_MSB = (QM_ID_WIDTH > 0) ? QM_ID_WIDTH - 1 : 0;

logic               head_valid;
logic               head_ready;
logic [QM_ID_MSB:0] qm_id;

// Overflow is prevented upstream by the level threshold
sync_fifo #(
    .WIDTH ($bits(pcie_rx_pkg::queued_meta_t)),
    .DEPTH (IN_QUEUE_DEPTH)
) in_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (rec),
    .in_valid     (rec_valid),
    .in_ready     (),
    .out_data     (pqm_meta),
    .out_valid    (head_valid),
    .out_ready    (head_ready),
    .level        (in_queue_level)
);

// Flows are spread over the managers by the low bits of the queue id
always_comb begin
    if (QM_ID_WIDTH > 0) begin
        qm_id = pqm_meta.pkt_queue_id[QM_ID_MSB:0];
    end else begin
        qm_id = '0;
    end
end

always_comb begin
    pqm_valid = '0;
    pqm_valid[qm_id] = head_valid;
end

assign head_ready = pqm_ready[qm_id];

endmodule

// File: rtl/pcie_rx_meta_top.sv
`timescale 1ns/1ps

module pcie_rx_meta_top #(
    parameter int HEAD_QUEUE_DEPTH = 128,
    parameter int IN_QUEUE_DEPTH = 8,
    parameter int NB_PKT_QUEUE_MANAGERS = 2,
    parameter int MAX_NB_FLOWS = pcie_rx_pkg::MAX_NB_FLOWS
) (
    input  logic                             pcie_clk,
    input  logic                             pcie_reset_n,

    input  pcie_rx_pkg::mmio_write_t         mmio_wr,
    input  logic                             sw_reset_req,

    input  pcie_rx_pkg::rx_meta_t            rx_meta,
    input  logic                             rx_meta_valid,
    output logic                             rx_meta_ready,

    output pcie_rx_pkg::queued_meta_t        pqm_meta,
    output logic [NB_PKT_QUEUE_MANAGERS-1:0] pqm_valid,
    input  logic [NB_PKT_QUEUE_MANAGERS-1:0] pqm_ready,

    output logic                             sw_reset,
    output logic [31:0]                      rx_ignored_head_cnt,
    output logic [31:0]                      rx_pkt_head_upd_cnt
);

pcie_rx_pkg::flow_idx_t    head_flow;
logic                      head_valid;
logic                      head_ready;
pcie_rx_pkg::queued_meta_t rec;
logic                      rec_valid;
logic [31:0]               in_queue_level;

head_upd_monitor #(
    .HEAD_QUEUE_DEPTH (HEAD_QUEUE_DEPTH),
    .MAX_NB_FLOWS     (MAX_NB_FLOWS)
) head_upd_monitor_inst (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .mmio_wr             (mmio_wr),
    .sw_reset_req        (sw_reset_req),
    .head_flow           (head_flow),
    .head_valid          (head_valid),
    .head_ready          (head_ready),
    .sw_reset            (sw_reset),
    .rx_ignored_head_cnt (rx_ignored_head_cnt)
);

meta_merge_arbiter #(
    .IN_QUEUE_DEPTH (IN_QUEUE_DEPTH)
) meta_merge_arbiter_inst (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .sw_reset            (sw_reset),
    .head_flow           (head_flow),
    .head_valid          (head_valid),
    .head_ready          (head_ready),
    .rx_meta             (rx_meta),
    .rx_meta_valid       (rx_meta_valid),
    .rx_meta_ready       (rx_meta_ready),
    .in_queue_level      (in_queue_level),
    .rec                 (rec),
    .rec_valid           (rec_valid),
    .rx_pkt_head_upd_cnt (rx_pkt_head_upd_cnt)
);

pqm_dispatch #(
    .IN_QUEUE_DEPTH        (IN_QUEUE_DEPTH),
    .NB_PKT_QUEUE_MANAGERS (NB_PKT_QUEUE_MANAGERS)
) pqm_dispatch_inst (
    .pcie_clk       (pcie_clk),
    .pcie_reset_n   (pcie_reset_n),
    .rec            (rec),
    .rec_valid      (rec_valid),
    .in_queue_level (in_queue_level),
    .pqm_meta       (pqm_meta),
    .pqm_valid      (pqm_valid),
    .pqm_ready      (pqm_ready)
);

endmodule

// File: sim/pcie_rx_meta_assertions.sv
`timescale 1ns/1ps

module pcie_rx_meta_assertions #(
    parameter int NB_PKT_QUEUE_MANAGERS = 2
) (
    input logic                             pcie_clk,
    input logic                             pcie_reset_n,
    input logic                             sw_reset_req,
    input logic                             sw_reset,
    input logic                             rx_meta_ready,
    input pcie_rx_pkg::queued_meta_t        pqm_meta,
    input logic [NB_PKT_QUEUE_MANAGERS-1:0] pqm_valid,
    input logic [NB_PKT_QUEUE_MANAGERS-1:0] pqm_ready,
    input logic [31:0]                      rx_ignored_head_cnt,
    input logic [31:0]                      rx_pkt_head_upd_cnt
);

int error_count = 0;

// Outputs come out of reset idle with cleared counters
reset_idle: assert property (@(posedge pcie_clk)
    !pcie_reset_n |=> (pqm_valid == '0) && !rx_meta_ready &&
        (rx_ignored_head_cnt == 0) && (rx_pkt_head_upd_cnt == 0))
    else begin
        error_count = error_count + 1;
        $error("Outputs not idle or counters not zero after reset");
    end

port_match: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    (pqm_valid != '0) |-> $onehot0(pqm_valid) && pqm_valid[pqm_meta.pkt_queue_id[0]])
    else begin
        error_count = error_count + 1;
        $error("Record offered on the wrong manager port or on several ports");
    end

desc_only_fields: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    ((pqm_valid != '0) && pqm_meta.descriptor_only) |->
        (pqm_meta.size == '0) && !pqm_meta.needs_dsc)
    else begin
        error_count = error_count + 1;
        $error("Descriptor-only record with nonzero size or needs_dsc set");
    end

needs_dsc_packet: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    ((pqm_valid != '0) && pqm_meta.needs_dsc) |-> !pqm_meta.descriptor_only)
    else begin
        error_count = error_count + 1;
        $error("Record flagged both needs_dsc and descriptor-only");
    end

sw_reset_delay: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    sw_reset == $past(sw_reset_req, 2))
    else begin
        error_count = error_count + 1;
        $error("sw_reset does not follow sw_reset_req by two cycles");
    end

sw_reset_clears: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    $rose(sw_reset) |=> (rx_pkt_head_upd_cnt == 0))
    else begin
        error_count = error_count + 1;
        $error("Head update counter not cleared by software reset");
    end

// A stalled port keeps its record on the bus
hold_on_stall: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    ((pqm_valid & ~pqm_ready) != '0) |=> $stable(pqm_valid) && $stable(pqm_meta))
    else begin
        error_count = error_count + 1;
        $error("pqm_valid or pqm_meta changed while the port was stalled");
    end

endmodule

// File: sim/pcie_rx_meta_tb.sv
`timescale 1ns/1ps

module pcie_rx_meta_tb;

localparam int N_HEAD = 16;
localparam int N_META = 32;
localparam int N_PAIR = 16;
localparam int N_BAD = 8;
// Per-item cycle budget of each phase, plus reset, drain and margin
localparam int TEST_CYCLES = 8 * N_HEAD + 12 * N_META + 20 * N_PAIR + 6 * N_BAD + 300;

logic                      pcie_clk = 1'b0;
logic                      pcie_reset_n;
pcie_rx_pkg::mmio_write_t  mmio_wr;
logic                      sw_reset_req;
pcie_rx_pkg::rx_meta_t     rx_meta;
logic                      rx_meta_valid;
logic                      rx_meta_ready;
pcie_rx_pkg::queued_meta_t pqm_meta;
logic [1:0]                pqm_valid;
logic [1:0]                pqm_ready;
logic                      sw_reset;
logic [31:0]               rx_ignored_head_cnt;
logic [31:0]               rx_pkt_head_upd_cnt;

integer seed;
logic   random_ready;
int     heads_sent;
int     metas_sent;
int     head_recs;
int     meta_recs;

pcie_rx_meta_top #(.NB_PKT_QUEUE_MANAGERS(2)) dut0 (.*);

bind pcie_rx_meta_top pcie_rx_meta_assertions #(
    .NB_PKT_QUEUE_MANAGERS (NB_PKT_QUEUE_MANAGERS)
) checks0 (.*);

always #4 pcie_clk = ~pcie_clk;

always @(negedge pcie_clk) begin
    if (random_ready) begin
        pqm_ready = 2'($random(seed));
    end else begin
        pqm_ready = 2'b11;
    end
end

// A merged record counts both as a head record and as a packet record
always @(posedge pcie_clk) begin
    if (pcie_reset_n && ((pqm_valid & pqm_ready) != 2'b00)) begin
        if (pqm_meta.descriptor_only || pqm_meta.needs_dsc) begin
            head_recs++;
        end
        if (!pqm_meta.descriptor_only) begin
            meta_recs++;
        end
    end
end

always @(negedge pcie_clk) begin
    if (dut0.checks0.error_count != 0) begin
        $display("FAIL: see errors above");
        $fatal(1, "A concurrent assertion failed");
    end
end

initial begin
    #(TEST_CYCLES * 8);
    $display("FAIL: see errors above");
    $fatal(1, "Timeout after %0d cycles, records still missing", TEST_CYCLES);
end

task automatic write_head(input int queue, input logic [63:0] byteenable);
    @(negedge pcie_clk);
    mmio_wr.address = {36'b0, 16'(queue), 12'h004};
    mmio_wr.byteenable = byteenable;
    mmio_wr.write = 1'b1;
    @(negedge pcie_clk);
    mmio_wr.write = 1'b0;
endtask

task automatic send_meta(input int queue, input int size);
    @(negedge pcie_clk);
    rx_meta.dsc_queue_id = 4'(queue);
    rx_meta.pkt_queue_id = 6'(queue);
    rx_meta.size = 16'(size);
    rx_meta_valid = 1'b1;
    do begin
        @(posedge pcie_clk);
    end while (!rx_meta_ready);
    metas_sent++;
    @(negedge pcie_clk);
    rx_meta_valid = 1'b0;
endtask

task automatic check_count(input string name, input logic [31:0] got, input int expected);
    if (got != 32'(expected)) begin
        $display("Fail %0t: %s is %0d, expected %0d", $time, name, got, expected);
        $display("FAIL: see errors above");
        $fatal(1, "Counter mismatch");
    end
endtask

initial begin
    seed = 32'h53f1a977;
    pcie_reset_n = 1'b0;
    mmio_wr = '0;
    sw_reset_req = 1'b0;
    rx_meta = '0;
    rx_meta_valid = 1'b0;
    pqm_ready = 2'b11;
    random_ready = 1'b0;
    heads_sent = 0;
    metas_sent = 0;
    head_recs = 0;
    meta_recs = 0;
    repeat (2) @(negedge pcie_clk);
    pcie_reset_n = 1'b1;
    repeat (2) @(negedge pcie_clk);

    for (int i = 0; i < N_HEAD; i++) begin
        write_head((i * 3) % 64, 64'hf0);
        heads_sent++;
        repeat (4) @(negedge pcie_clk);
    end

    random_ready = 1'b1;
    for (int i = 0; i < N_META; i++) begin
        send_meta((i * 5) % 64, 64 + i);
    end

    // Even pairs target the same queue and should merge, odd pairs differ
    for (int i = 0; i < N_PAIR; i++) begin
        write_head(i, 64'hf0);
        heads_sent++;
        send_meta((i % 2 == 0) ? i : i + 1, 100 + i);
    end

    for (int i = 0; i < N_BAD; i++) begin
        write_head(i, 64'h30);
        write_head(64 + i * 7, 64'hf0);
    end

    while (head_recs < heads_sent || meta_recs < metas_sent) begin
        @(negedge pcie_clk);
    end
    repeat (8) @(negedge pcie_clk);
    check_count("dispatched head records", 32'(head_recs), heads_sent);
    check_count("dispatched packet records", 32'(meta_recs), metas_sent);
    check_count("rx_pkt_head_upd_cnt", rx_pkt_head_upd_cnt, heads_sent);
    check_count("rx_ignored_head_cnt", rx_ignored_head_cnt, 0);

    sw_reset_req = 1'b1;
    @(negedge pcie_clk);
    sw_reset_req = 1'b0;
    repeat (6) @(negedge pcie_clk);

    if (dut0.checks0.error_count != 0) begin
        $display("FAIL: see errors above");
        $fatal(1, "Assertion failures detected at end of run");
    end else begin
        $display("PASS: all tests");
        $finish;
    end
end

endmodule

// File: build.f
rtl/pcie_rx_pkg.sv
rtl/sync_fifo.sv
rtl/head_upd_monitor.sv
rtl/meta_merge_arbiter.sv
rtl/pqm_dispatch.sv
rtl/pcie_rx_meta_top.sv
sim/pcie_rx_meta_assertions.sv
sim/pcie_rx_meta_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := pcie_rx_meta_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
FLAGS     := --timing --assert
SIM_ARGS  := +verilator+error+limit+100

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
